/* source/lcdSpi_defs.svh */
// size macros for the LCD SPI link, included by the package and any RTL that needs bit counts
`ifndef LCD_SPI_DEFS_SVH
`define LCD_SPI_DEFS_SVH

// bits in one command or parameter byte
`define LCD_BYTE_BITS 8

// bits in one pixel word (RGB565)
`define LCD_WORD_BITS 16

// clk cycles per SCK phase, so one SCK period is twice this
// 1 gives SCK at half the clk rate, values up to 4 are fine
`define LCD_SCK_HALF 1

`endif

/* source/lcdSpiPkg.sv */
// shared types of the LCD SPI link: host word views, decoded command and host status word
`include "lcdSpi_defs.svh"

package lcdSpiPkg;

	// byte view of the host word, used by the load strobe
	typedef struct packed {
		logic [`LCD_WORD_BITS-`LCD_BYTE_BITS-3:0] rsvd; // bits 15:10, not decoded
		logic dcSel;                                    // DCX level, 0 = command, 1 = data
		logic csRelease;                                // raise CSX, no bits shifted
		logic [`LCD_BYTE_BITS-1:0] data;                // command or parameter byte
	} hostByte_s;

	// the host word, read as a byte request on load and as a pixel on load16
	typedef union packed {
		hostByte_s byteView;
		logic [`LCD_WORD_BITS-1:0] pixelView;
	} hostWord_u;

	// command handed from decode to the shifter and the line control
	typedef struct packed {
		logic start;                          // begin shifting
		logic csRelease;                      // raise CSX only
		logic isWord;                         // 16 bits instead of 8
		logic dcx;                            // DCX level for this transfer
		logic [`LCD_WORD_BITS-1:0] payload;   // MSB first, bytes left-aligned
	} spiCmd_s;

	// status word seen by the host
	typedef struct packed {
		logic busy;              // bit 15, transfer in progress
		logic [14:0] frameCount; // completed transfers, wraps
	} lcdStatus_s;

endpackage

/* source/lcdCmdDecode.sv */
// decode stage: samples host strobes, picks the union view and registers one SPI command
`include "lcdSpi_defs.svh"

module lcdCmdDecode (
	input logic clk,
	input logic rstN,
	input logic load,                       // byte strobe
	input logic load16,                     // pixel strobe, wins over load
	input lcdSpiPkg::hostWord_u in,
	input logic busy,                       // shifter is running
	output lcdSpiPkg::spiCmd_s cmd,
	output logic cmdValid                   // one-cycle pulse with cmd
);

	logic accept;                 // strobe taken this cycle
	logic pendValid;              // first stage holds a strobe
	logic pendIsWord;             // that strobe was load16
	lcdSpiPkg::hostWord_u pendWord;
	lcdSpiPkg::spiCmd_s nextCmd;

	// one command at a time: anything already in flight or shifting blocks new strobes
	assign accept = (load | load16) & ~busy & ~cmdValid & ~pendValid;

	// first stage, capture strobe kind and host word
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pendValid <= 1'b0;
			pendIsWord <= 1'b0;
		end else begin
			pendValid <= accept;
			if (accept)
				pendIsWord <= load16; // load16 has priority
		end
	end

	// word itself is payload, no reset
	always_ff @(posedge clk) begin
		if (accept)
			pendWord <= in;
	end

	// build the command from whichever view the strobe asked for
	always_comb begin
		nextCmd = '0;
		if (pendIsWord) begin
			nextCmd.start = 1'b1;
			nextCmd.isWord = 1'b1;
			nextCmd.dcx = 1'b1;                     // pixels are always data
			nextCmd.payload = pendWord.pixelView;
		end else begin
			nextCmd.start = ~pendWord.byteView.csRelease;
			nextCmd.csRelease = pendWord.byteView.csRelease;
			nextCmd.dcx = pendWord.byteView.dcSel;  // DCX follows even on release
			// byte sits in the top bits so the shifter always sends from bit 15
			nextCmd.payload = {pendWord.byteView.data,
				{(`LCD_WORD_BITS - `LCD_BYTE_BITS){1'b0}}};
		end
	end

	// second stage, registered command and its valid pulse
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			cmdValid <= 1'b0;
		else
			cmdValid <= pendValid;
	end

	always_ff @(posedge clk) begin
		if (pendValid)
			cmd <= nextCmd;
	end

endmodule

/* source/lcdSpiShifter.sv */
// execute stage: shifts the command payload out MSB first on SDO and generates SCK
`include "lcdSpi_defs.svh"

module lcdSpiShifter (
	input logic clk,
	input logic rstN,
	input lcdSpiPkg::spiCmd_s cmd,
	input logic cmdValid,
	output logic sck,     // idles low, mode 0
	output logic sdo,
	output logic busy,    // high for the whole transfer
	output logic done     // last cycle of busy
);

	// phase counter must be at least one bit wide even for a half period of 1
	localparam int PhaseW = ($clog2(`LCD_SCK_HALF) > 0) ? $clog2(`LCD_SCK_HALF) : 1;
	localparam int CountW = $clog2(`LCD_WORD_BITS + 1);

	logic [`LCD_WORD_BITS-1:0] shiftReg;  // bit 15 drives SDO
	logic [CountW-1:0] bitCount;          // bits still to finish
	logic [PhaseW-1:0] phase;             // cycles spent in the current SCK phase
	logic phaseEnd;                       // SCK toggles at the next edge
	logic fallEdge;                       // SCK goes high to low at the next edge
	logic loadCmd;

	assign loadCmd = cmdValid & cmd.start;
	assign phaseEnd = (phase == PhaseW'(`LCD_SCK_HALF - 1));
	assign fallEdge = busy & sck & phaseEnd;

	// final falling edge of the last bit
	assign done = fallEdge & (bitCount == CountW'(1));

	// SDO is held low between transfers
	assign sdo = busy & shiftReg[`LCD_WORD_BITS-1];

	// SCK, phase and bit counters
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			sck <= 1'b0;
			phase <= '0;
			bitCount <= '0;
		end else if (loadCmd) begin
			busy <= 1'b1;
			sck <= 1'b0;  // first bit is set up during a full low phase
			phase <= '0;
			bitCount <= cmd.isWord ? CountW'(`LCD_WORD_BITS) : CountW'(`LCD_BYTE_BITS);
		end else if (busy) begin
			if (phaseEnd) begin
				phase <= '0;
				sck <= ~sck;
				if (sck) begin
					// a bit is complete once SCK falls
					bitCount <= bitCount - CountW'(1);
					if (bitCount == CountW'(1))
						busy <= 1'b0;
				end
			end else begin
				phase <= phase + PhaseW'(1);
			end
		end
	end

	// data register, shifts only after a falling SCK edge so the rising edge sees a stable bit
	always_ff @(posedge clk) begin
		if (loadCmd)
			shiftReg <= cmd.payload;
		else if (fallEdge)
			shiftReg <= {shiftReg[`LCD_WORD_BITS-2:0], 1'b0};
	end

endmodule

/* source/lcdLineControl.sv */
// result stage: holds the CSX and DCX lines and builds the host status word
module lcdLineControl (
	input logic clk,
	input logic rstN,
	input lcdSpiPkg::spiCmd_s cmd,
	input logic cmdValid,
	input logic done,                        // one pulse per finished transfer
	input logic busy,
	output logic csx,                        // chip select, active low
	output logic dcx,                        // 0 = command, 1 = data
	output lcdSpiPkg::lcdStatus_s status
);

	logic [14:0] frameCount;  // matches the status field, wraps

	// CSX goes low with a start and stays low after the transfer;
	// only a release takes it high again, after the last SCK fall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			csx <= 1'b1; // panel deselected out of reset
		end else if (cmdValid) begin
			if (cmd.start)
				csx <= 1'b0;
			else if (cmd.csRelease)
				csx <= 1'b1;
		end
	end

	// DCX takes the new level on every command, release included
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			dcx <= 1'b0;
		else if (cmdValid)
			dcx <= cmd.dcx;
	end

	// count finished transfers, releases never pulse done
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			frameCount <= '0;
		else if (done)
			frameCount <= frameCount + 15'd1;
	end

	// busy comes straight from the shifter so the host sees it from the load cycle
	always_comb begin
		status.busy = busy;
		status.frameCount = frameCount;
	end

endmodule

/* source/lcdSpi.sv */
// top of the write-only LCD SPI link: host strobes in, CSX/DCX/SDO/SCK and status out
module lcdSpi (
	input logic clk,
	input logic rstN,
	input logic load,                       // send byte or release, per in word
	input logic load16,                     // send 16-bit pixel
	input lcdSpiPkg::hostWord_u in,
	output lcdSpiPkg::lcdStatus_s out,      // busy and transfer count
	output logic DCX,
	output logic CSX,
	output logic SDO,
	output logic SCK
);

	lcdSpiPkg::spiCmd_s cmd;
	logic cmdValid;
	logic busy;
	logic done;

	// strobe to registered command
	lcdCmdDecode decodeInst (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.load16(load16),
		.in(in),
		.busy(busy),
		.cmd(cmd),
		.cmdValid(cmdValid)
	);

	// serializer and SCK
	lcdSpiShifter shifterInst (
		.clk(clk),
		.rstN(rstN),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.sck(SCK),
		.sdo(SDO),
		.busy(busy),
		.done(done)
	);

	// CSX, DCX and status word
	lcdLineControl lineInst (
		.clk(clk),
		.rstN(rstN),
		.cmd(cmd),
		.cmdValid(cmdValid),
		.done(done),
		.busy(busy),
		.csx(CSX),
		.dcx(DCX),
		.status(out)
	);

endmodule

/* test/lcdSpi_chk.sv */
// SPI protocol assertions, bound into the lcdSpi top level
module lcdSpiChk (
	input logic clk,
	input logic rstN,
	input logic sck,
	input logic sdo,
	input logic csx,
	input logic busy
);
	timeunit 1ns;
	timeprecision 100ps;

	// an SCK edge needs the shifter running on the cycle before it
	sckOnlyBusy: assert property (@(posedge clk) disable iff (!rstN)
		(sck != $past(sck)) |-> $past(busy))
		else $error("SCK toggled while the shifter was idle");

	// panel samples on the rising edge, data must hold through the high phase
	sdoStableHigh: assert property (@(posedge clk) disable iff (!rstN)
		sck |-> (sdo == $past(sdo)))
		else $error("SDO changed while SCK was high");

	sdoNoCsxRise: assert property (@(posedge clk) disable iff (!rstN)
		(csx && !$past(csx)) |-> (!busy && !$past(busy)))
		else $error("CSX rose during a transfer");

	// checked on the cycle reset is released
	resetIdle: assert property (@(posedge clk)
		$rose(rstN) |-> (csx && !sck))
		else $error("CSX or SCK not idle at reset release");

endmodule

bind lcdSpi lcdSpiChk chkInst (
	.clk(clk),
	.rstN(rstN),
	.sck(SCK),
	.sdo(SDO),
	.csx(CSX),
	.busy(busy)
);

/* test/lcdSpiMonitor.sv */
// testbench monitor that rebuilds SPI transfers from the pins and compares them with queued expectations
module lcdSpiMonitor (
	input logic clk,
	input logic rstN,
	input logic sck,
	input logic sdo,
	input logic csx,
	input logic dcx,
	input lcdSpiPkg::lcdStatus_s status
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [4:0] nBits;   // 8 or 16
		logic [15:0] bits;   // right-aligned with the MSB sent first
		logic dcx;
	} expect_s;

	expect_s expQ[$];        // transfers the host has asked for
	int errorCount;
	int doneCount;           // transfers finished so far
	int bitCount;            // rising SCK edges in this transfer
	logic [15:0] shiftIn;
	logic prevSck;
	logic prevBusy;

	initial begin
		errorCount = 0;
		doneCount = 0;
		bitCount = 0;
		shiftIn = '0;
		prevSck = 1'b0;
		prevBusy = 1'b0;
	end

	task automatic reportValue(input string name, input logic [15:0] got,
		input logic [15:0] want);
		errorCount++;
		$display("error at %0t: %s got %h expected %h", $time, name, got, want);
	endtask

	task automatic reportEvent(input string what);
		errorCount++;
		$display("at %0t: %s", $time, what);
	endtask

	task automatic expectTransfer(input int nBits, input logic [15:0] bits,
		input logic dcxLevel);
		expect_s e;
		e.nBits = 5'(nBits);
		e.bits = bits;
		e.dcx = dcxLevel;
		expQ.push_back(e);
	endtask

	// idle lines and status checked by the testbench between operations
	task automatic checkLines(input logic expDcx, input logic expCsx, input int expFrames);
		if (csx !== expCsx)
			reportValue("CSX", 16'(csx), 16'(expCsx));
		if (dcx !== expDcx)
			reportValue("DCX", 16'(dcx), 16'(expDcx));
		if (sck !== 1'b0)
			reportValue("SCK", 16'(sck), 16'h0);
		if (sdo !== 1'b0)
			reportValue("SDO", 16'(sdo), 16'h0);
		if (status.busy !== 1'b0)
			reportValue("status.busy", 16'(status.busy), 16'h0);
		if (status.frameCount !== 15'(expFrames))
			reportValue("status.frameCount", 16'(status.frameCount), 16'(expFrames));
	endtask

	task automatic finishTransfer;
		expect_s head;
		if (expQ.size() == 0) begin
			reportEvent("a transfer ended that no strobe asked for");
		end else begin
			head = expQ.pop_front();
			doneCount++;
			if (bitCount != int'(head.nBits))
				reportValue("SCK rising edges", 16'(bitCount), 16'(head.nBits));
			if (shiftIn !== head.bits)
				reportValue("SDO word", shiftIn, head.bits);
			if (dcx !== head.dcx)
				reportValue("DCX", 16'(dcx), 16'(head.dcx));
			if (status.frameCount !== 15'(doneCount)) // counts on the same edge busy falls
				reportValue("status.frameCount", 16'(status.frameCount), 16'(doneCount));
		end
		bitCount = 0;
		shiftIn = '0;
	endtask

	task automatic finalCheck;
		if (expQ.size() != 0)
			reportEvent($sformatf("%0d expected transfers never completed", expQ.size()));
	endtask

	// sampled on the clock so every value is the one settled after the previous edge
	always @(posedge clk) begin
		if (!rstN) begin
			prevSck = 1'b0;
			prevBusy = 1'b0;
			bitCount = 0;
			shiftIn = '0;
		end else begin
			if (sck && !prevSck) begin
				if (csx !== 1'b0)
					reportEvent("SCK rose while CSX was high");
				if (status.busy !== 1'b1)
					reportEvent("SCK rose while status.busy was low");
				if (expQ.size() == 0)
					reportEvent("SCK rose with no transfer expected");
				shiftIn = {shiftIn[14:0], sdo}; // MSB arrives first
				bitCount++;
			end
			if (status.busy && !prevBusy && expQ.size() == 0)
				reportEvent("busy rose with no transfer expected");
			if (!status.busy && prevBusy)
				finishTransfer();
			prevSck = sck;
			prevBusy = status.busy;
		end
	end

endmodule

/* test/lcdSpiTb.sv */
// testbench top for the LCD SPI link that drives clock and reset, replays the testdata file and prints the summary
`include "lcdSpi_defs.svh"

module lcdSpiTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WaitLimit = 60; // cycles before a wait gives up

	logic clk;
	logic rstN;
	logic load;
	logic load16;
	lcdSpiPkg::hostWord_u hostIn;
	lcdSpiPkg::lcdStatus_s status;
	logic dcxPin;
	logic csxPin;
	logic sdoPin;
	logic sckPin;

	int timeoutCount;   // waits that ran out
	int dataErrors;     // unreadable testdata lines
	int expFrames;      // transfers the testdata has asked for
	integer seed;       // for the values of dropped strobes

	lcdSpi u_dut (
		.clk(clk),
		.rstN(rstN),
		.load(load),
		.load16(load16),
		.in(hostIn),
		.out(status),
		.DCX(dcxPin),
		.CSX(csxPin),
		.SDO(sdoPin),
		.SCK(sckPin)
	);

	// rebuilds each transfer from the pins and does all comparing
	lcdSpiMonitor monInst (
		.clk(clk),
		.rstN(rstN),
		.sck(sckPin),
		.sdo(sdoPin),
		.csx(csxPin),
		.dcx(dcxPin),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// inputs change 2 ns after the rising edge
	task automatic nextCycle;
		@(posedge clk);
		#2;
	endtask

	task automatic waitCycles(input int n);
		for (int i = 0; i < n; i++)
			nextCycle();
	endtask

	// one-cycle strobe, sampled by the next rising edge
	task automatic pulseStrobe(input logic isWord, input logic [15:0] word);
		hostIn.pixelView = word;
		load = ~isWord;
		load16 = isWord;
		nextCycle();
		load = 1'b0;
		load16 = 1'b0;
	endtask

	// counted wait for status.busy to reach a level
	task automatic waitBusy(input logic level, input string what);
		int n;
		n = 0;
		while (status.busy !== level && n < WaitLimit) begin
			nextCycle();
			n++;
		end
		if (status.busy !== level) begin
			timeoutCount++;
			$display("timeout at %0t: busy never went to %0d while waiting for %s",
				$time, level, what);
		end
	endtask

	// expected bits for one testdata line follow the host word layout
	task automatic runOperation(input logic [7:0] op, input logic [15:0] word,
		input logic expDcx, input logic expCsx);
		lcdSpiPkg::hostWord_u hw;
		hw.pixelView = word;
		case (op)
			"B": begin
				monInst.expectTransfer(`LCD_BYTE_BITS, {8'h00, hw.byteView.data},
					hw.byteView.dcSel);
				expFrames++;
				pulseStrobe(1'b0, word);
				waitBusy(1'b1, "byte start");
				waitBusy(1'b0, "byte end");
			end
			"W": begin
				monInst.expectTransfer(`LCD_WORD_BITS, word, 1'b1); // pixels are data
				expFrames++;
				pulseStrobe(1'b1, word);
				waitBusy(1'b1, "word start");
				waitBusy(1'b0, "word end");
			end
			"R": begin
				pulseStrobe(1'b0, word);
				waitCycles(3);   // release settles after two edges
			end
			"D": begin
				// only the first byte may go out
				monInst.expectTransfer(`LCD_BYTE_BITS, {8'h00, hw.byteView.data},
					hw.byteView.dcSel);
				expFrames++;
				pulseStrobe(1'b0, word);
				pulseStrobe(1'b1, 16'($random(seed)));  // while decode holds the strobe
				pulseStrobe(1'b1, 16'($random(seed)));  // while cmdValid is high
				waitBusy(1'b1, "byte start before drop");
				pulseStrobe(1'b1, 16'($random(seed)));  // while shifting
				waitBusy(1'b0, "byte end after drop");
			end
			default: begin
				dataErrors++;
				$display("unknown operation code %h in testdata", op);
			end
		endcase
		monInst.checkLines(expDcx, expCsx, expFrames);
	endtask

	initial begin
		int fd;
		int ch;
		int code;
		logic [15:0] word;
		logic expDcx;
		logic expCsx;
		load = 1'b0;
		load16 = 1'b0;
		hostIn = '0;
		rstN = 1'b0;
		timeoutCount = 0;
		dataErrors = 0;
		expFrames = 0;
		seed = 32'he14a_3a34;

		repeat (4) @(posedge clk); // reset held 4 cycles
		#2;
		rstN = 1'b1;
		nextCycle();
		monInst.checkLines(1'b0, 1'b1, 0); // idle state out of reset

		fd = $fopen("test/lcdSpi_testdata.txt", "r");
		if (fd == 0) begin
			dataErrors++;
			$display("could not open the testdata file test/lcdSpi_testdata.txt");
		end else begin
			ch = $fgetc(fd);
			while (ch >= 0) begin
				if (ch[7:0] == "#") begin
					// comment runs to end of line
					while (ch >= 0 && ch[7:0] != 8'h0a)
						ch = $fgetc(fd);
				end else if (ch[7:0] == "B" || ch[7:0] == "W" || ch[7:0] == "R"
					|| ch[7:0] == "D") begin
					code = $fscanf(fd, "%h %h %h", word, expDcx, expCsx);
					if (code != 3) begin
						dataErrors++;
						$display("testdata line for operation %c has missing fields", ch[7:0]);
					end else begin
						runOperation(ch[7:0], word, expDcx, expCsx);
					end
				end else if (ch[7:0] != " " && ch[7:0] != 8'h09 && ch[7:0] != 8'h0a
					&& ch[7:0] != 8'h0d) begin
					dataErrors++;
					$display("testdata holds an unexpected character %c", ch[7:0]);
				end
				ch = $fgetc(fd);
			end
			$fclose(fd);
		end

		monInst.finalCheck();
		$display("errors: compare %0d, timeout %0d, testdata %0d",
			monInst.errorCount, timeoutCount, dataErrors);
		if (monInst.errorCount + timeoutCount + dataErrors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* test/lcdSpi_testdata.txt */
# op: B byte, W pixel word, R release CSX, D byte with extra strobes that must be dropped
# columns: op, host word hex (bit 9 dcSel, bit 8 release, 7:0 byte), expected DCX, expected CSX
B 002a 0 0
B 0200 1 0
B 0200 1 0
B 0200 1 0
B 02ef 1 0
B 002b 0 0
B 0201 1 0
B 023f 1 0
B 002c 0 0
W f800 1 0
W 07e0 1 0
W 001f 1 0
W a5c3 1 0
R 0100 0 1
B 0036 0 0
B 0248 1 0
R 0300 1 1
D 0011 0 0
D 02ff 1 0
W ffff 1 0
W 0000 1 0
W 8001 1 0
R 0100 0 1
B 0029 0 0
R 0100 0 1

/* verilog.f */
+incdir+source
source/lcdSpiPkg.sv
source/lcdCmdDecode.sv
source/lcdSpiShifter.sv
source/lcdLineControl.sv
source/lcdSpi.sv
test/lcdSpi_chk.sv
test/lcdSpiMonitor.sv
test/lcdSpiTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --assert --timing --timescale 1ns/100ps
TOP = lcdSpiTb
FILELIST = verilog.f
BUILD_DIR = obj_dir
LOG = sim.log

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = $(wildcard source/*.svh)
TESTDATA = test/lcdSpi_testdata.txt

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM) $(TESTDATA)
	./$(SIM) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
